/* project.f */
+incdir+rtl
+incdir+verification
rtl/pipe_ctrl_pkg.sv
rtl/cw_decoder.sv
rtl/fwd_unit.sv
rtl/stall_flush_ctrl.sv
rtl/pipe_ctrl_top.sv
verification/pipe_ctrl_tb.sv

/* Bender.yml */
package:
  name: pipe_ctrl

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/pipe_ctrl_pkg.sv
      - rtl/cw_decoder.sv
      - rtl/fwd_unit.sv
      - rtl/stall_flush_ctrl.sv
      - rtl/pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/pipe_ctrl_tb.sv

/* verification/pipe_ctrl_vectors.svh */
`ifndef PIPE_CTRL_VECTORS_SVH
`define PIPE_CTRL_VECTORS_SVH

// one row per cycle, history after each row in brackets (youngest first)
task automatic build_table;
    ctrl_word_t    e;
    instr_fields_t f;
    // lui x1 [1,0,0], auipc x2 [2,1,0]
    e = write_cw(5'd1);
    e.exe.exe_fwd_sel = exe_fwd_u_imm;
    e.wb.wb_sel = wb_u_imm;
    add_run(make_fields(op_lui, 3'd0, rnd_f7(), 5'd1, rnd_reg(), rnd_reg()), e);
    e = write_cw(5'd2);
    e.exe.alu_src1 = alu1_pc;
    e.exe.alu_src2 = alu2_u_imm;
    add_run(make_fields(op_auipc, 3'd0, rnd_f7(), 5'd2, rnd_reg(), rnd_reg()), e);
    // alu group, each source checked against the history
    add_run(make_fields(op_reg, 3'b000, 7'h00, 5'd3, 5'd1, 5'd2),
            alu_cw(5'd3, alu_add, alu2_rs2, fwd_mem, fwd_exe));
    add_run(make_fields(op_reg, 3'b000, 7'h20, 5'd4, 5'd1, 5'd3),
            alu_cw(5'd4, alu_sub, alu2_rs2, fwd_wb, fwd_exe));
    add_run(make_fields(op_imm, 3'b100, rnd_f7(), 5'd0, 5'd4, rnd_reg()),
            alu_cw(5'd0, alu_xor, alu2_i_imm, fwd_exe, fwd_reg_data));
    // slti from x0 [5,0,4]
    e = alu_cw(5'd5, alu_add, alu2_i_imm, fwd_reg_data, fwd_reg_data);
    e.exe.cmp_op = cmp_blt;
    e.exe.cmp_sel = cmp_i_imm;
    e.exe.exe_fwd_sel = exe_fwd_br_en_zext;
    e.wb.wb_sel = wb_br_en;
    add_run(make_fields(op_imm, 3'b010, rnd_f7(), 5'd5, 5'd0, rnd_reg()), e);
    e = alu_cw(5'd6, alu_add, alu2_rs2, fwd_exe, fwd_wb);
    e.exe.cmp_op = cmp_bltu;
    e.exe.exe_fwd_sel = exe_fwd_br_en_zext;
    e.wb.wb_sel = wb_br_en;
    add_run(make_fields(op_reg, 3'b011, 7'h00, 5'd6, 5'd5, 5'd4), e);
    add_run(make_fields(op_imm, 3'b101, 7'h20, 5'd7, 5'd6, rnd_reg()),
            alu_cw(5'd7, alu_sra, alu2_i_imm, fwd_exe, fwd_reg_data));
    add_run(make_fields(op_reg, 3'b101, 7'h00, 5'd8, 5'd5, 5'd6),
            alu_cw(5'd8, alu_srl, alu2_rs2, fwd_wb, fwd_mem));
    add_run(make_fields(op_imm, 3'b001, 7'h00, 5'd9, 5'd8, rnd_reg()),
            alu_cw(5'd9, alu_sll, alu2_i_imm, fwd_exe, fwd_reg_data));
    add_run(make_fields(op_reg, 3'b110, 7'h00, 5'd10, 5'd7, 5'd9),
            alu_cw(5'd10, alu_or, alu2_rs2, fwd_wb, fwd_exe));
    add_run(make_fields(op_imm, 3'b111, rnd_f7(), 5'd11, 5'd10, rnd_reg()),
            alu_cw(5'd11, alu_and, alu2_i_imm, fwd_exe, fwd_reg_data));
    // lw x12 then lbu x13 [13,12,11]
    e = write_cw(5'd12);
    e.mem.mem_fwd_sel = mem_fwd_mem_data;
    e.mem.read = 1'b1;
    e.mem.funct3 = 3'b010;
    e.mem.mar_sel = mar_alu_out;
    e.wb.wb_sel = wb_lw;
    e.exe.rs1_sel = fwd_exe;
    add_run(make_fields(op_load, 3'b010, rnd_f7(), 5'd12, 5'd11, rnd_reg()), e);
    e.wb.rd = 5'd13;
    e.mem.funct3 = 3'b100;
    e.wb.wb_sel = wb_lbu;
    e.exe.rs1_sel = fwd_reg_data;
    add_run(make_fields(op_load, 3'b100, rnd_f7(), 5'd13, 5'd0, rnd_reg()), e);
    // sw writes no register, history gets x0 [0,13,12]
    e = CW_DEFAULT;
    e.exe.alu_src2 = alu2_s_imm;
    e.mem.write = 1'b1;
    e.mem.funct3 = 3'b010;
    e.mem.mar_sel = mar_alu_out;
    e.exe.rs1_sel = fwd_exe;
    e.exe.rs2_sel = fwd_mem;
    add_run(make_fields(op_store, 3'b010, rnd_f7(), rnd_reg(), 5'd13, 5'd12), e);
    // jumps and branches [1,0,13] [2,1,0] [0,2,1] [0,0,2]
    e = write_cw(5'd1);
    e.exe.alu_src1 = alu1_pc;
    e.exe.alu_src2 = alu2_j_imm;
    e.wb.wb_sel = wb_pc_plus4;
    add_row(make_fields(op_jal, 3'd0, rnd_f7(), 5'd1, rnd_reg(), rnd_reg()), e,
            ST_GO, 1'b1, 1'b0, op_jal, PR_RUN, pc_alu_out, 1'b1, 1'b0);
    // comparator high under jalr is not a taken branch
    e = write_cw(5'd2);
    e.wb.wb_sel = wb_pc_plus4;
    e.exe.rs1_sel = fwd_wb;
    add_row(make_fields(op_jalr, 3'd0, rnd_f7(), 5'd2, 5'd13, rnd_reg()), e,
            ST_GO, 1'b1, 1'b1, op_jalr, PR_RUN, pc_alu_mod2, 1'b1, 1'b0);
    e = write_cw(5'd0);
    e.wb.ld_reg = 1'b0;
    e.exe.alu_src1 = alu1_pc;
    e.exe.alu_src2 = alu2_b_imm;
    e.exe.cmp_op = cmp_bne;
    e.exe.rs1_sel = fwd_exe;
    e.exe.rs2_sel = fwd_mem;
    add_row(make_fields(op_br, 3'b001, rnd_f7(), 5'd0, 5'd2, 5'd1), e,
            ST_GO, 1'b1, 1'b1, op_br, 8'b1111_1100, pc_alu_out, 1'b1, 1'b0);
    e.exe.cmp_op = cmp_bgeu;
    e.exe.rs1_sel = fwd_wb;
    e.exe.rs2_sel = fwd_reg_data;
    add_row(make_fields(op_br, 3'b111, rnd_f7(), 5'd0, 5'd1, 5'd0), e,
            ST_GO, 1'b1, 1'b0, op_br, PR_RUN, pc_plus4, 1'b1, 1'b0);
    // fetch not ready gives the bubble [0,0,0]
    add_row(make_fields(op_lui, 3'd0, rnd_f7(), 5'd3, rnd_reg(), rnd_reg()), CW_DEFAULT,
            10'b10_11_11_11_11, 1'b1, 1'b0, op_imm, PR_RUN, pc_plus4, 1'b1, 1'b0);
    // an empty stage has nothing to pass on, x0 keeps [0,0,0]
    f = make_fields(op_imm, 3'b000, rnd_f7(), 5'd0, 5'd14, rnd_reg());
    e = alu_cw(5'd0, alu_add, alu2_i_imm, fwd_reg_data, fwd_reg_data);
    add_row(f, e, 10'b11_01_11_01_11, 1'b1, 1'b0, op_imm, 8'b1010_0000, pc_plus4, 1'b1, 1'b0);
    add_row(f, e, 10'b11_11_01_11_11, 1'b1, 1'b0, op_imm, 8'b1101_0000, pc_plus4, 1'b1, 1'b0);
    // back-pressure from each stage, then a missing icache response
    f = make_fields(op_imm, 3'b000, rnd_f7(), 5'd14, 5'd14, rnd_reg());
    e = alu_cw(5'd14, alu_add, alu2_i_imm, fwd_reg_data, fwd_reg_data);
    add_row(f, e, 10'b11_11_11_11_10, 1'b1, 1'b0, op_imm, 8'b0000_0000, pc_plus4, 1'b0, 1'b0);
    add_row(f, e, 10'b11_11_11_10_11, 1'b1, 1'b0, op_imm, 8'b0001_0000, pc_plus4, 1'b0, 1'b0);
    add_row(f, e, 10'b11_11_10_11_11, 1'b1, 1'b0, op_imm, 8'b0011_0000, pc_plus4, 1'b0, 1'b0);
    add_row(f, e, 10'b11_10_11_11_11, 1'b1, 1'b0, op_imm, 8'b0111_0000, pc_plus4, 1'b0, 1'b0);
    add_row(f, e, ST_GO, 1'b0, 1'b0, op_imm, 8'b0000_0000, pc_plus4, 1'b0, 1'b1);
    // a stall also holds the fetch, a taken branch still loads the pc
    add_row(f, e, 10'b11_10_11_11_11, 1'b0, 1'b0, op_imm, 8'b0000_0000, pc_plus4, 1'b0, 1'b0);
    add_row(f, e, ST_GO, 1'b0, 1'b1, op_br, 8'b0000_1100, pc_alu_out, 1'b1, 1'b1);
    // held rows did not shift, so x14 is still not in flight
    add_run(make_fields(op_imm, 3'b000, rnd_f7(), 5'd15, 5'd14, rnd_reg()),
            alu_cw(5'd15, alu_add, alu2_i_imm, fwd_reg_data, fwd_reg_data));
    add_run(make_fields(op_imm, 3'b000, rnd_f7(), 5'd1, 5'd15, rnd_reg()),
            alu_cw(5'd1, alu_add, alu2_i_imm, fwd_exe, fwd_reg_data));
endtask

`endif

/* verification/pipe_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_tb
    import pipe_ctrl_pkg::*;
;

    localparam stage_status_t ST_GO  = 10'b11_11_11_11_11;
    localparam pipe_regs_t    PR_RUN = 8'b1111_0000;

    typedef struct packed {
        instr_fields_t fields;
        stage_status_t status;
        logic          resp;
        logic          br_en;
        opcode_t       exe_op;
        ctrl_word_t    exp_cw;
        pipe_regs_t    exp_regs;
        pc_sel_t       exp_pc;
        logic          exp_load_pc;
        logic          exp_imem_read;
    } vector_t;

    logic          clk;
    logic          rst;
    instr_fields_t fields;
    stage_status_t status;
    logic          icache_resp;
    logic          br_en;
    opcode_t       exe_opcode;
    ctrl_word_t    ctrl_word;
    pipe_regs_t    pipe_regs;
    pc_sel_t       pc_sel;
    logic          load_pc;
    logic          imem_read;

    vector_t vecs[$];
    integer  seed;
    integer  pass_cnt;
    integer  fail_cnt;
    logic    row_fail;
    string   label;

    pipe_ctrl_top i_pipe_ctrl_top (
        .clk           (clk),
        .rst           (rst),
        .i_fields      (fields),
        .i_status      (status),
        .i_icache_resp (icache_resp),
        .i_br_en       (br_en),
        .i_exe_opcode  (exe_opcode),
        .o_ctrl_word   (ctrl_word),
        .o_pipe_regs   (pipe_regs),
        .o_pc_sel      (pc_sel),
        .o_load_pc     (load_pc),
        .o_imem_read   (imem_read)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic reg_addr_t rnd_reg();
        return reg_addr_t'($random(seed));
    endfunction

    function automatic funct7_t rnd_f7();
        return funct7_t'($random(seed));
    endfunction

    function automatic instr_fields_t make_fields(opcode_t op, funct3_t f3, funct7_t f7,
                                                  reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        instr_fields_t f;
        f.opcode = op;
        f.funct3 = f3;
        f.funct7 = f7;
        f.rd = rd;
        f.rs1 = rs1;
        f.rs2 = rs2;
        return f;
    endfunction

    // instruction that writes rd with an execute-stage result
    function automatic ctrl_word_t write_cw(reg_addr_t rd);
        ctrl_word_t c;
        c = CW_DEFAULT;
        c.wb.ld_reg = 1'b1;
        c.wb.rd = rd;
        c.mem.mem_fwd_sel = mem_fwd_exe_fwd;
        return c;
    endfunction

    function automatic ctrl_word_t alu_cw(reg_addr_t rd, alu_op_t op, alu_src2_t src2,
                                          fwd_sel_t sel1, fwd_sel_t sel2);
        ctrl_word_t c;
        c = write_cw(rd);
        c.exe.alu_op = op;
        c.exe.alu_src2 = src2;
        c.exe.rs1_sel = sel1;
        c.exe.rs2_sel = sel2;
        return c;
    endfunction

    task automatic add_row(instr_fields_t f, ctrl_word_t e, stage_status_t st, logic resp,
                           logic br, opcode_t xop, pipe_regs_t pr, pc_sel_t pc,
                           logic ldpc, logic imrd);
        vector_t v;
        v = '{f, st, resp, br, xop, e, pr, pc, ldpc, imrd};
        vecs.push_back(v);
    endtask

    // all stages flowing, no branch in execute
    task automatic add_run(instr_fields_t f, ctrl_word_t e);
        add_row(f, e, ST_GO, 1'b1, 1'b0, op_imm, PR_RUN, pc_plus4, 1'b1, 1'b0);
    endtask

    `include "pipe_ctrl_vectors.svh"

    task automatic check_ctrl_word(ctrl_word_t got, ctrl_word_t exp);
        if (got !== exp) begin
            $display("FAILED %s o_ctrl_word: got %h expected %h", label, got, exp);
            row_fail = 1'b1;
        end
    endtask

    task automatic check_pipe_regs(pipe_regs_t got, pipe_regs_t exp);
        if (got !== exp) begin
            $display("FAILED %s o_pipe_regs: got %h expected %h", label, got, exp);
            row_fail = 1'b1;
        end
    endtask

    task automatic check_pc_sel(pc_sel_t got, pc_sel_t exp);
        if (got !== exp) begin
            $display("FAILED %s o_pc_sel: got %h expected %h", label, got, exp);
            row_fail = 1'b1;
        end
    endtask

    task automatic check_fetch(logic got_ld, logic exp_ld, logic got_rd, logic exp_rd);
        if (got_ld !== exp_ld) begin
            $display("FAILED %s o_load_pc: got %h expected %h", label, got_ld, exp_ld);
            row_fail = 1'b1;
        end
        if (got_rd !== exp_rd) begin
            $display("FAILED %s o_imem_read: got %h expected %h", label, got_rd, exp_rd);
            row_fail = 1'b1;
        end
    endtask

    task automatic report_row();
        if (row_fail) begin
            fail_cnt++;
            $display("%s: mismatch", label);
        end else begin
            pass_cnt++;
            $display("%s: ok", label);
        end
    endtask

    // everything held, whatever the stages and the fetch say
    task automatic check_reset_outputs();
        row_fail = 1'b0;
        check_ctrl_word(ctrl_word, CW_DEFAULT);
        check_pipe_regs(pipe_regs, 8'b0000_1111);
        check_pc_sel(pc_sel, pc_plus4);
        check_fetch(load_pc, 1'b0, imem_read, 1'b0);
        report_row();
    endtask

    initial begin
        integer cnt;
        vector_t v;
        seed = 32'h100d5126;
        pass_cnt = 0;
        fail_cnt = 0;
        rst = 1'b1;
        // fetch ready with a writing instruction in decode
        fields = make_fields(op_lui, 3'd0, 7'h00, 5'd1, 5'd0, 5'd0);
        status = ST_GO;
        icache_resp = 1'b0;
        br_en = 1'b0;
        exe_opcode = op_imm;
        build_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        label = "reset without response";
        check_reset_outputs();
        @(posedge clk);
        #1 icache_resp = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        label = "reset with response";
        check_reset_outputs();
        @(posedge clk);
        #1;
        rst = 1'b0;
        fields = '0;
        status = '0;
        icache_resp = 1'b0;

        // flushes drop once reset is gone
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while ((pipe_regs.mem_wb_flush !== 1'b0) && (cnt < 20));
        if (pipe_regs.mem_wb_flush !== 1'b0) begin
            $display("reset release timed out, flushes still high");
            $display("Some tests failed");
            $finish;
        end

        for (int i = 0; i < vecs.size(); i++) begin
            v = vecs[i];
            @(posedge clk);
            #1;
            fields = v.fields;
            status = v.status;
            icache_resp = v.resp;
            br_en = v.br_en;
            exe_opcode = v.exe_op;
            @(negedge clk);
            label = $sformatf("row %0d", i);
            row_fail = 1'b0;
            check_ctrl_word(ctrl_word, v.exp_cw);
            check_pipe_regs(pipe_regs, v.exp_regs);
            check_pc_sel(pc_sel, v.exp_pc);
            check_fetch(load_pc, v.exp_load_pc, imem_read, v.exp_imem_read);
            report_row();
        end

        $display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/pipe_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top
    import pipe_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  instr_fields_t i_fields,
    input  stage_status_t i_status,
    input  logic          i_icache_resp,
    input  logic          i_br_en,
    input  opcode_t       i_exe_opcode,
    output ctrl_word_t    o_ctrl_word,
    output pipe_regs_t    o_pipe_regs,
    output pc_sel_t       o_pc_sel,
    output logic          o_load_pc,
    output logic          o_imem_read
);

    ctrl_word_t dec_cw;
    logic       uses_rs1;
    logic       uses_rs2;
    reg_addr_t  hist_rd;
    fwd_sel_t   rs1_sel;
    fwd_sel_t   rs2_sel;

    // decode holds the bubble through reset
    cw_decoder i_cw_decoder (
        .i_fields   (i_fields),
        .i_if_rdy   (i_status.if_ready & ~rst),
        .o_cw       (dec_cw),
        .o_uses_rs1 (uses_rs1),
        .o_uses_rs2 (uses_rs2),
        .o_hist_rd  (hist_rd)
    );

    // history advances with the if/de register
    fwd_unit i_fwd_unit (
        .clk        (clk),
        .rst        (rst),
        .i_shift    (o_pipe_regs.if_de_ld),
        .i_hist_rd  (hist_rd),
        .i_rs1      (i_fields.rs1),
        .i_rs2      (i_fields.rs2),
        .i_uses_rs1 (uses_rs1),
        .i_uses_rs2 (uses_rs2),
        .o_rs1_sel  (rs1_sel),
        .o_rs2_sel  (rs2_sel)
    );

    stall_flush_ctrl i_stall_flush_ctrl (
        .clk           (clk),
        .rst           (rst),
        .i_status      (i_status),
        .i_icache_resp (i_icache_resp),
        .i_br_en       (i_br_en),
        .i_exe_opcode  (i_exe_opcode),
        .o_pipe_regs   (o_pipe_regs),
        .o_pc_sel      (o_pc_sel),
        .o_load_pc     (o_load_pc),
        .o_imem_read   (o_imem_read)
    );

    // forwarding selects go into the decoded word
    always_comb begin
        o_ctrl_word             = dec_cw;
        o_ctrl_word.exe.rs1_sel = rs1_sel;
        o_ctrl_word.exe.rs2_sel = rs2_sel;
    end

endmodule

`default_nettype wire

/* rtl/stall_flush_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_ctrl_settings.svh"

module stall_flush_ctrl
    import pipe_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  stage_status_t i_status,
    input  logic          i_icache_resp,
    input  logic          i_br_en,
    input  opcode_t       i_exe_opcode,
    output pipe_regs_t    o_pipe_regs,
    output pc_sel_t       o_pc_sel,
    output logic          o_load_pc,
    output logic          o_imem_read
);

    // stage 1 is decode, stage NUM_STAGES-1 is writeback
    logic [`NUM_STAGES-1:1] vld;
    logic [`NUM_STAGES-1:1] rdy;
    logic [`NUM_STAGES-1:1] blocked;
    logic [`NUM_STAGES:1]   stall_from;
    logic [`NUM_STAGES-2:0] ld;
    logic                   branch_taken;

    assign vld = {i_status.wb_valid, i_status.mem_valid, i_status.exe_valid, i_status.de_valid};
    assign rdy = {i_status.wb_ready, i_status.mem_ready, i_status.exe_ready, i_status.de_ready};
    assign blocked = vld & ~rdy;

    assign branch_taken = i_br_en && (i_exe_opcode == op_br);

    // stall_from[k] is high when stage k or any later one holds
    always_comb begin
        stall_from[`NUM_STAGES] = 1'b0;
        for (int k = `NUM_STAGES - 1; k >= 1; k--) begin
            stall_from[k] = blocked[k] | stall_from[k + 1];
        end
    end

    // register j sits between stage j and stage j+1
    always_comb begin
        ld[0] = i_icache_resp & ~stall_from[1];
        for (int j = 1; j < `NUM_STAGES - 1; j++) begin
            ld[j] = i_icache_resp & ~stall_from[j + 1] & vld[j];
        end
    end

    always_comb begin
        if (rst) begin
            o_pipe_regs = '{default: 1'b0, if_de_flush: 1'b1, de_exe_flush: 1'b1,
                            exe_mem_flush: 1'b1, mem_wb_flush: 1'b1};
            o_load_pc   = 1'b0;
            o_imem_read = 1'b0;
        end else begin
            o_pipe_regs.if_de_ld      = ld[0];
            o_pipe_regs.de_exe_ld     = ld[1];
            o_pipe_regs.exe_mem_ld    = ld[2];
            o_pipe_regs.mem_wb_ld     = ld[3];
            // the two younger instructions are on the wrong path
            o_pipe_regs.if_de_flush   = branch_taken;
            o_pipe_regs.de_exe_flush  = branch_taken;
            o_pipe_regs.exe_mem_flush = 1'b0;
            o_pipe_regs.mem_wb_flush  = 1'b0;
            o_load_pc   = branch_taken | ld[0];
            o_imem_read = ~i_icache_resp & ~stall_from[1];
        end
    end

    always_comb begin
        if (branch_taken || (i_exe_opcode == op_jal)) begin
            o_pc_sel = pc_alu_out;
        end else if (i_exe_opcode == op_jalr) begin
            o_pc_sel = pc_alu_mod2;
        end else begin
            o_pc_sel = pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* rtl/fwd_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_ctrl_settings.svh"

module fwd_unit
    import pipe_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_shift,
    input  reg_addr_t i_hist_rd,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  logic      i_uses_rs1,
    input  logic      i_uses_rs2,
    output fwd_sel_t  o_rs1_sel,
    output fwd_sel_t  o_rs2_sel
);

    // entry 0 is the youngest destination
    reg_addr_t [`FWD_DEPTH-1:0] hist;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist <= '0;
        end else if (i_shift) begin
            hist <= {hist[`FWD_DEPTH-2:0], i_hist_rd};
        end
    end

    function automatic fwd_sel_t pick_src(
        input reg_addr_t [`FWD_DEPTH-1:0] h,
        input reg_addr_t                  rs,
        input logic                       used
    );
        fwd_sel_t sel;
        sel = fwd_reg_data;
        if (used && (rs != '0)) begin
            // oldest first, so the closest match is the one that sticks
            for (int i = `FWD_DEPTH - 1; i >= 0; i--) begin
                if (h[i] == rs) begin
                    sel = fwd_sel_t'(2'(i + 1));
                end
            end
        end
        return sel;
    endfunction

    assign o_rs1_sel = pick_src(hist, i_rs1, i_uses_rs1);
    assign o_rs2_sel = pick_src(hist, i_rs2, i_uses_rs2);

endmodule

`default_nettype wire

/* rtl/cw_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cw_decoder
    import pipe_ctrl_pkg::*;
(
    input  instr_fields_t i_fields,
    input  logic          i_if_rdy,
    output ctrl_word_t    o_cw,
    output logic          o_uses_rs1,
    output logic          o_uses_rs2,
    output reg_addr_t     o_hist_rd
);

    ctrl_word_t cw;
    logic       is_reg;

    // imm and reg share one decode, only the second operand differs
    assign is_reg = (i_fields.opcode == op_reg);

    always_comb begin
        cw         = CW_DEFAULT;
        o_uses_rs1 = 1'b0;
        o_uses_rs2 = 1'b0;

        // nothing fetched yet, keep the bubble
        if (i_if_rdy) begin
            case (i_fields.opcode)
                op_lui: begin
                    cw.exe.exe_fwd_sel = exe_fwd_u_imm;
                    cw.mem.mem_fwd_sel = mem_fwd_exe_fwd;
                    cw.wb.ld_reg       = 1'b1;
                    cw.wb.wb_sel       = wb_u_imm;
                    cw.wb.rd           = i_fields.rd;
                end

                op_auipc: begin
                    cw.exe.alu_src1    = alu1_pc;
                    cw.exe.alu_src2    = alu2_u_imm;
                    cw.mem.mem_fwd_sel = mem_fwd_exe_fwd;
                    cw.wb.ld_reg       = 1'b1;
                    cw.wb.rd           = i_fields.rd;
                end

                op_jal: begin
                    cw.exe.alu_src1    = alu1_pc;
                    cw.exe.alu_src2    = alu2_j_imm;
                    cw.mem.mem_fwd_sel = mem_fwd_exe_fwd;
                    cw.wb.ld_reg       = 1'b1;
                    cw.wb.wb_sel       = wb_pc_plus4;
                    cw.wb.rd           = i_fields.rd;
                end

                op_jalr: begin
                    // target is rs1 + i_imm, the default operands
                    cw.mem.mem_fwd_sel = mem_fwd_exe_fwd;
                    cw.wb.ld_reg       = 1'b1;
                    cw.wb.wb_sel       = wb_pc_plus4;
                    cw.wb.rd           = i_fields.rd;
                    o_uses_rs1         = 1'b1;
                end

                op_br: begin
                    // alu builds the target, comparator decides
                    cw.exe.alu_src1    = alu1_pc;
                    cw.exe.alu_src2    = alu2_b_imm;
                    cw.mem.mem_fwd_sel = mem_fwd_exe_fwd;
                    case (i_fields.funct3)
                        3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111: begin
                            cw.exe.cmp_op = cmp_op_t'(i_fields.funct3);
                        end
                        default: ;
                    endcase
                    o_uses_rs1 = 1'b1;
                    o_uses_rs2 = 1'b1;
                end

                op_load: begin
                    cw.mem.read    = 1'b1;
                    cw.mem.funct3  = i_fields.funct3;
                    cw.mem.mar_sel = mar_alu_out;
                    cw.wb.ld_reg   = 1'b1;
                    cw.wb.rd       = i_fields.rd;
                    case (i_fields.funct3)
                        3'b000:  cw.wb.wb_sel = wb_lb;
                        3'b001:  cw.wb.wb_sel = wb_lh;
                        3'b010:  cw.wb.wb_sel = wb_lw;
                        3'b100:  cw.wb.wb_sel = wb_lbu;
                        3'b101:  cw.wb.wb_sel = wb_lhu;
                        default: ;
                    endcase
                    o_uses_rs1 = 1'b1;
                end

                op_store: begin
                    cw.exe.alu_src2 = alu2_s_imm;
                    cw.mem.write    = 1'b1;
                    cw.mem.funct3   = i_fields.funct3;
                    cw.mem.mar_sel  = mar_alu_out;
                    o_uses_rs1      = 1'b1;
                    o_uses_rs2      = 1'b1;
                end

                op_imm, op_reg: begin
                    cw.exe.alu_src2    = is_reg ? alu2_rs2 : alu2_i_imm;
                    cw.mem.mem_fwd_sel = mem_fwd_exe_fwd;
                    cw.wb.ld_reg       = 1'b1;
                    cw.wb.rd           = i_fields.rd;
                    case (i_fields.funct3)
                        3'b000: begin
                            // addi has no sub form
                            cw.exe.alu_op = (is_reg && i_fields.funct7[5]) ? alu_sub : alu_add;
                        end
                        3'b001: cw.exe.alu_op = alu_sll;
                        3'b010, 3'b011: begin
                            // slt/sltu come out of the comparator
                            cw.exe.cmp_op      = i_fields.funct3[0] ? cmp_bltu : cmp_blt;
                            cw.exe.cmp_sel     = is_reg ? cmp_rs2 : cmp_i_imm;
                            cw.exe.exe_fwd_sel = exe_fwd_br_en_zext;
                            cw.wb.wb_sel       = wb_br_en;
                        end
                        3'b100: cw.exe.alu_op = alu_xor;
                        3'b101: cw.exe.alu_op = i_fields.funct7[5] ? alu_sra : alu_srl;
                        3'b110: cw.exe.alu_op = alu_or;
                        default: cw.exe.alu_op = alu_and;
                    endcase
                    o_uses_rs1 = 1'b1;
                    o_uses_rs2 = is_reg;
                end

                default: ;
            endcase
        end
    end

    assign o_cw = cw;

    // x0 in the history never matches a used source
    assign o_hist_rd = cw.wb.ld_reg ? cw.wb.rd : '0;

endmodule

`default_nettype wire

/* rtl/pipe_ctrl_pkg.sv */
`default_nettype none

`include "pipe_ctrl_settings.svh"

package pipe_ctrl_pkg;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`FUNCT3_W-1:0]   funct3_t;
    typedef logic [`FUNCT7_W-1:0]   funct7_t;

    // base opcodes of the rv32i groups
    typedef enum logic [`OPCODE_W-1:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
    } alu_op_t;

    // values follow the branch funct3 encoding
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {alu1_rs1, alu1_pc} alu_src1_t;

    typedef enum logic [2:0] {
        alu2_i_imm, alu2_u_imm, alu2_b_imm, alu2_s_imm, alu2_j_imm, alu2_rs2
    } alu_src2_t;

    typedef enum logic {cmp_rs2, cmp_i_imm} cmp_src_t;

    // operand source seen by execute
    typedef enum logic [1:0] {fwd_reg_data, fwd_exe, fwd_mem, fwd_wb} fwd_sel_t;

    typedef enum logic [1:0] {exe_fwd_alu_out, exe_fwd_u_imm, exe_fwd_br_en_zext} exe_fwd_sel_t;
    typedef enum logic {mem_fwd_mem_data, mem_fwd_exe_fwd} mem_fwd_sel_t;
    typedef enum logic {mar_pc, mar_alu_out} mar_sel_t;

    typedef enum logic [3:0] {
        wb_alu_out, wb_u_imm, wb_br_en, wb_pc_plus4, wb_lb, wb_lh, wb_lw, wb_lbu, wb_lhu
    } wb_sel_t;

    typedef enum logic [1:0] {pc_plus4, pc_alu_out, pc_alu_mod2} pc_sel_t;

    typedef struct packed {
        opcode_t   opcode;
        funct3_t   funct3;
        funct7_t   funct7;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } instr_fields_t;

    typedef struct packed {
        cmp_src_t     cmp_sel;
        alu_src1_t    alu_src1;
        alu_src2_t    alu_src2;
        fwd_sel_t     rs1_sel;
        fwd_sel_t     rs2_sel;
        cmp_op_t      cmp_op;
        alu_op_t      alu_op;
        exe_fwd_sel_t exe_fwd_sel;
    } exe_ctrl_t;

    typedef struct packed {
        logic         read;
        logic         write;
        funct3_t      funct3;
        mar_sel_t     mar_sel;
        mem_fwd_sel_t mem_fwd_sel;
    } mem_ctrl_t;

    typedef struct packed {
        logic      ld_reg;
        wb_sel_t   wb_sel;
        reg_addr_t rd;
    } wb_ctrl_t;

    typedef struct packed {
        exe_ctrl_t exe;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
    } ctrl_word_t;

    typedef struct packed {
        logic if_valid;
        logic if_ready;
        logic de_valid;
        logic de_ready;
        logic exe_valid;
        logic exe_ready;
        logic mem_valid;
        logic mem_ready;
        logic wb_valid;
        logic wb_ready;
    } stage_status_t;

    typedef struct packed {
        logic if_de_ld;
        logic de_exe_ld;
        logic exe_mem_ld;
        logic mem_wb_ld;
        logic if_de_flush;
        logic de_exe_flush;
        logic exe_mem_flush;
        logic mem_wb_flush;
    } pipe_regs_t;

    // bubble: add rs1 + i_imm, nothing written anywhere
    localparam ctrl_word_t CW_DEFAULT = '{
        exe: '{cmp_sel: cmp_rs2, alu_src1: alu1_rs1, alu_src2: alu2_i_imm,
               rs1_sel: fwd_reg_data, rs2_sel: fwd_reg_data, cmp_op: cmp_beq,
               alu_op: alu_add, exe_fwd_sel: exe_fwd_alu_out},
        mem: '{read: 1'b0, write: 1'b0, funct3: '0, mar_sel: mar_pc,
               mem_fwd_sel: mem_fwd_mem_data},
        wb:  '{ld_reg: 1'b0, wb_sel: wb_alu_out, rd: '0}
    };

endpackage

`default_nettype wire

/* rtl/pipe_ctrl_settings.svh */
`ifndef PIPE_CTRL_SETTINGS_SVH
`define PIPE_CTRL_SETTINGS_SVH

// rv32i instruction field widths
`define REG_ADDR_W 5
`define OPCODE_W   7
`define FUNCT3_W   3
`define FUNCT7_W   7

// fetch, decode, execute, memory, writeback
`define NUM_STAGES 5

// destinations still in flight ahead of decode
`define FWD_DEPTH  3

`endif
